/* rtl/hyper_pkg.sv */
// HyperRAM controller shared widths, command-address layout, counter loads and kinds
package hyper_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int DQ_W   = 8;
  localparam int WORD_W = 32;
  localparam int BE_W   = 4;
  localparam int CA_W   = 48;
  // Only the low bits of the 8-bit core latency ports are used
  localparam int LAT_W  = 6;

  // --------------------------------------------------------------------------
  // Command-address bit positions
  // --------------------------------------------------------------------------
  localparam int CA_RW_BIT    = 47;
  localparam int CA_AS_BIT    = 46;
  localparam int CA_BURST_BIT = 45;
  // Row and upper column field
  localparam int CA_ROW_HI    = 44;
  localparam int CA_ROW_LO    = 16;
  // Lower column field sits at the bottom
  localparam int CA_COL_HI    = 2;

  // --------------------------------------------------------------------------
  // Counter loads
  // --------------------------------------------------------------------------
  // Power-up hold after reset, in fabric clocks
  localparam int RESET_HOLD    = 60;
  // Half DRAM clock slots spent on command-address
  localparam int CA_SLOTS      = 7;
  localparam int MEM_BYTES     = 4;
  localparam int REG_BYTES     = 2;
  // Reads really end on the strobe, this is only the upper bound
  localparam int READ_WAIT_MAX = 63;

  // Counter widths derived from the loads
  localparam int HOLD_W     = $clog2(RESET_HOLD + 1);
  localparam int SLOT_W     = $clog2(CA_SLOTS + 1);
  localparam int BYTE_CNT_W = $clog2(MEM_BYTES + 1);

  // Transaction kind latched on request
  typedef enum logic [1:0] {
    XACT_MEM_RD = 2'd0,
    XACT_MEM_WR = 2'd1,
    XACT_REG_WR = 2'd2
  } xact_kind_t;

endpackage

/* rtl/hyper_pins_if.sv */
// Pin-level link between the HyperRAM sequencer and the pad flops
interface hyper_pins_if
  import hyper_pkg::*;
();

  // Byte to place on DQ for the next half DRAM clock
  logic [DQ_W-1:0] byte_out;
  // RWDS write mask, high means the byte is not written
  logic            mask;
  // Output enables, active high before the pad inversion
  logic            dq_oe;
  logic            rwds_oe;
  // Chip select, active high before the pad inversion
  logic            cs;
  // Transaction in progress, runs the DRAM clock
  logic            run;

  // One-flop samples of the input pins
  logic            rwds_in;
  logic [DQ_W-1:0] dq_in;

  modport seq (
    output byte_out, mask, dq_oe, rwds_oe, cs, run,
    input  rwds_in, dq_in
  );

  modport pad (
    input  byte_out, mask, dq_oe, rwds_oe, cs, run,
    output rwds_in, dq_in
  );

endinterface

/* rtl/hyper_sequencer.sv */
// HyperRAM transaction sequencer: CA packing, hold/address/latency/data counters, CS
module hyper_sequencer
  import hyper_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              rd_req,
  input  logic              wr_req,
  input  logic              mem_or_reg,
  input  logic [BE_W-1:0]   wr_byte_en,
  input  logic [WORD_W-1:0] addr,
  input  logic [WORD_W-1:0] wr_d,
  input  logic [LAT_W-1:0]  latency_1x,
  input  logic [LAT_W-1:0]  latency_2x,
  input  logic              word_done,
  hyper_pins_if.seq         pins,
  output logic              read_active,
  output logic              busy
);

  logic [HOLD_W-1:0]     hold_cnt;
  logic                  pending;
  logic                  run;
  logic                  run_d1;
  logic                  phs;
  logic                  slot_tick;
  logic                  cs_q;
  logic [1:0]            cs_d;
  logic [SLOT_W-1:0]     addr_cnt;
  logic [LAT_W-1:0]      wait_cnt;
  logic [BYTE_CNT_W-1:0] data_cnt;
  logic [LAT_W-1:0]      lat_sel;
  xact_kind_t            kind;
  logic                  accept;
  logic [CA_W-1:0]       ca_word;
  logic [CA_W-1:0]       ca_sr;
  logic [WORD_W-1:0]     data_sr;
  logic [BE_W-1:0]       be_sr;

  // Requests only count while the previous transaction is fully closed
  assign accept    = ~busy & (rd_req | wr_req);
  // One slot per DRAM clock edge, every second fabric clock
  assign slot_tick = run & phs;
  // RWDS high during CA asks for the doubled latency
  assign lat_sel   = pins.rwds_in ? latency_2x : latency_1x;

  assign pins.run  = run;
  assign pins.cs   = cs_q;

  // --------------------------------------------------------------------------
  // Command-address packing
  // --------------------------------------------------------------------------
  always_comb begin
    ca_word               = '0;
    ca_word[CA_RW_BIT]    = rd_req;
    ca_word[CA_AS_BIT]    = mem_or_reg;
    // Always linear burst
    ca_word[CA_BURST_BIT] = 1'b1;
    if (!mem_or_reg) begin
      // Memory is word addressed, a dword starts on an even word
      ca_word[CA_ROW_HI:CA_ROW_LO] = addr[30:2];
      ca_word[CA_COL_HI:0]         = {addr[1:0], 1'b0};
    end else begin
      // Registers keep the low address bits as they are
      ca_word[CA_ROW_HI:CA_ROW_LO] = addr[31:3];
      ca_word[CA_COL_HI:0]         = addr[2:0];
    end
  end

  // --------------------------------------------------------------------------
  // Control: hold, handshake, counters, chip select and direction
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_cnt     <= HOLD_W'(RESET_HOLD);
      pending      <= 1'b0;
      busy         <= 1'b0;
      run          <= 1'b0;
      run_d1       <= 1'b0;
      phs          <= 1'b0;
      cs_q         <= 1'b0;
      cs_d         <= 2'b00;
      addr_cnt     <= '0;
      wait_cnt     <= '0;
      data_cnt     <= '0;
      read_active  <= 1'b0;
      kind         <= XACT_MEM_WR;
      pins.dq_oe   <= 1'b0;
      pins.rwds_oe <= 1'b0;
    end else begin
      // Power-up hold
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end

      // Latch the request, it may have to wait for the hold to expire
      if (accept) begin
        pending <= 1'b1;
        busy    <= 1'b1;
        if (rd_req) begin
          kind <= XACT_MEM_RD;
        end else if (mem_or_reg) begin
          kind <= XACT_REG_WR;
        end else begin
          kind <= XACT_MEM_WR;
        end
      end

      // Launch
      if (pending && hold_cnt == '0) begin
        pending      <= 1'b0;
        run          <= 1'b1;
        addr_cnt     <= SLOT_W'(CA_SLOTS);
        pins.dq_oe   <= 1'b0;
        pins.rwds_oe <= 1'b0;
      end

      // Address slots, DQ driven and RWDS left to the memory
      if (slot_tick && addr_cnt != '0) begin
        addr_cnt     <= addr_cnt - 1'b1;
        pins.dq_oe   <= 1'b1;
        pins.rwds_oe <= 1'b0;
        if (addr_cnt == SLOT_W'(1)) begin
          case (kind)
            // Zero latency, data follows straight on
            XACT_REG_WR: data_cnt <= BYTE_CNT_W'(REG_BYTES);
            XACT_MEM_WR: begin
              if (lat_sel == '0) begin
                data_cnt <= BYTE_CNT_W'(MEM_BYTES);
              end else begin
                wait_cnt <= lat_sel;
              end
            end
            default: begin
              wait_cnt    <= LAT_W'(READ_WAIT_MAX);
              read_active <= 1'b1;
            end
          endcase
        end
      end

      // Latency, counted in fabric clocks
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
        if (wait_cnt == LAT_W'(1)) begin
          if (kind == XACT_MEM_RD) begin
            // No strobe ever came, give up on the read
            run         <= 1'b0;
            read_active <= 1'b0;
          end else begin
            data_cnt <= BYTE_CNT_W'(MEM_BYTES);
          end
        end
      end

      // Data slots
      if (slot_tick && data_cnt != '0) begin
        data_cnt <= data_cnt - 1'b1;
        if (data_cnt == BYTE_CNT_W'(1)) begin
          run <= 1'b0;
        end
      end

      // Turn the bus around after CA. Reads release both pins
      if (wait_cnt != '0 || data_cnt != '0) begin
        pins.dq_oe   <= (kind != XACT_MEM_RD);
        pins.rwds_oe <= (kind == XACT_MEM_WR);
      end

      // Read ends when the fourth byte is in
      if (word_done) begin
        run         <= 1'b0;
        read_active <= 1'b0;
        wait_cnt    <= '0;
      end

      phs    <= run ? ~phs : 1'b0;
      run_d1 <= run;

      // CS trails run by two clocks so the last byte sees a full clock edge
      cs_q <= run | run_d1;
      if (!run && !run_d1) begin
        pins.dq_oe   <= 1'b0;
        pins.rwds_oe <= 1'b0;
      end

      // Busy drops one clock after CS is back high at the pin
      cs_d <= {cs_d[0], cs_q};
      if (cs_d == 2'b10) begin
        busy <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Payload shift registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      ca_sr   <= ca_word;
      data_sr <= wr_d;
      be_sr   <= wr_byte_en;
    end
    if (slot_tick && addr_cnt != '0) begin
      pins.byte_out <= ca_sr[CA_W-1 -: DQ_W];
      ca_sr         <= {ca_sr[CA_W-DQ_W-1:0], DQ_W'(0)};
      pins.mask     <= 1'b1;
    end
    // Nothing gets written while waiting
    if (wait_cnt != '0) begin
      pins.mask <= 1'b1;
    end
    if (slot_tick && data_cnt != '0) begin
      pins.byte_out <= data_sr[WORD_W-1 -: DQ_W];
      data_sr       <= {data_sr[WORD_W-DQ_W-1:0], DQ_W'(0)};
      pins.mask     <= ~be_sr[BE_W-1];
      be_sr         <= {be_sr[BE_W-2:0], 1'b0};
    end
  end

endmodule

/* rtl/hyper_read_capture.sv */
// HyperRAM read strobe edge detect and assembly of four bytes into a word
module hyper_read_capture
  import hyper_pkg::*;
(
  input  logic              clk,
  input  logic              read_active,
  input  logic              rwds_in,
  input  logic [DQ_W-1:0]   dq_in,
  output logic [WORD_W-1:0] word,
  output logic              word_done
);

  logic       rwds_q;
  logic       armed;
  logic       dly;
  logic       sample_now;
  logic [1:0] byte_cnt;

  // --------------------------------------------------------------------------
  // Strobe phase tracking
  // --------------------------------------------------------------------------
  // A rising edge takes a byte at once and the falling edge two clocks later
  always_ff @(posedge clk) begin
    rwds_q     <= rwds_in;
    sample_now <= 1'b0;
    if (!read_active) begin
      armed <= 1'b1;
      dly   <= 1'b0;
    end else if (armed) begin
      if (rwds_in && !rwds_q) begin
        armed      <= 1'b0;
        dly        <= 1'b0;
        sample_now <= 1'b1;
      end
    end else begin
      dly <= 1'b1;
      // Second half of the strobe period, then look for the next rise
      if (dly) begin
        armed      <= 1'b1;
        sample_now <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Byte assembly, first byte lands in the top of the word
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    word_done <= 1'b0;
    if (!read_active) begin
      byte_cnt <= 2'd0;
    end
    if (sample_now) begin
      word     <= {word[WORD_W-DQ_W-1:0], dq_in};
      byte_cnt <= byte_cnt + 1'b1;
      if (byte_cnt == 2'd3) begin
        word_done <= 1'b1;
      end
    end
  end

endmodule

/* rtl/hyper_pad_stage.sv */
// HyperRAM pad stage with DRAM clock divider and registered pin flops
module hyper_pad_stage
  import hyper_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  hyper_pins_if.pad       pins,
  input  logic [DQ_W-1:0] dram_dq_in,
  input  logic            dram_rwds_in,
  output logic [DQ_W-1:0] dram_dq_out,
  output logic            dram_dq_oe_l,
  output logic            dram_rwds_out,
  output logic            dram_rwds_oe_l,
  output logic            dram_ck,
  output logic            dram_cs_l
);

  logic [1:0] ck_phs;
  logic       ck_d;

  // --------------------------------------------------------------------------
  // Control pins and the divide-by-four DRAM clock
  // --------------------------------------------------------------------------
  // The two clock delay flops centre the clock edges in the data eye
  always_ff @(posedge clk) begin
    if (reset) begin
      ck_phs         <= 2'd0;
      ck_d           <= 1'b0;
      dram_ck        <= 1'b0;
      dram_cs_l      <= 1'b1;
      dram_dq_oe_l   <= 1'b1;
      dram_rwds_oe_l <= 1'b1;
    end else begin
      // Clock only toggles during a transaction
      ck_phs         <= pins.run ? ck_phs + 1'b1 : 2'd0;
      ck_d           <= ck_phs[1];
      dram_ck        <= ck_d;
      dram_cs_l      <= ~pins.cs;
      dram_dq_oe_l   <= ~pins.dq_oe;
      dram_rwds_oe_l <= ~pins.rwds_oe;
    end
  end

  // --------------------------------------------------------------------------
  // Data pins
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    dram_dq_out   <= pins.byte_out;
    // RWDS doubles as write mask
    dram_rwds_out <= pins.mask;
    // Input samples
    pins.rwds_in  <= dram_rwds_in;
    pins.dq_in    <= dram_dq_in;
  end

endmodule

/* rtl/hyper_ctrl_top.sv */
// HyperRAM single-dword controller top with core-side and DRAM-side pins
module hyper_ctrl_top
  import hyper_pkg::*;
(
  input  logic              clk,
  input  logic              reset,

  // Core side
  input  logic              rd_req,
  input  logic              wr_req,
  input  logic              mem_or_reg,
  input  logic [BE_W-1:0]   wr_byte_en,
  input  logic [WORD_W-1:0] addr,
  input  logic [WORD_W-1:0] wr_d,
  input  logic [7:0]        latency_1x,
  input  logic [7:0]        latency_2x,
  output logic [WORD_W-1:0] rd_d,
  output logic              rd_rdy,
  output logic              busy,

  // DRAM side
  input  logic [DQ_W-1:0]   dram_dq_in,
  output logic [DQ_W-1:0]   dram_dq_out,
  output logic              dram_dq_oe_l,
  input  logic              dram_rwds_in,
  output logic              dram_rwds_out,
  output logic              dram_rwds_oe_l,
  output logic              dram_ck,
  output logic              dram_rst_l,
  output logic              dram_cs_l
);

  logic              read_active;
  logic              word_done;
  logic [WORD_W-1:0] word;

  hyper_pins_if pins ();

  // DRAM reset follows the core reset directly
  assign dram_rst_l = ~reset;

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------
  hyper_sequencer u_seq (
    .clk         (clk),
    .reset       (reset),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .mem_or_reg  (mem_or_reg),
    .wr_byte_en  (wr_byte_en),
    .addr        (addr),
    .wr_d        (wr_d),
    .latency_1x  (latency_1x[LAT_W-1:0]),
    .latency_2x  (latency_2x[LAT_W-1:0]),
    .word_done   (word_done),
    .pins        (pins.seq),
    .read_active (read_active),
    .busy        (busy)
  );

  // Only the two sampled inputs are needed here
  hyper_read_capture u_capture (
    .clk         (clk),
    .read_active (read_active),
    .rwds_in     (pins.rwds_in),
    .dq_in       (pins.dq_in),
    .word        (word),
    .word_done   (word_done)
  );

  hyper_pad_stage u_pad (
    .clk            (clk),
    .reset          (reset),
    .pins           (pins.pad),
    .dram_dq_in     (dram_dq_in),
    .dram_rwds_in   (dram_rwds_in),
    .dram_dq_out    (dram_dq_out),
    .dram_dq_oe_l   (dram_dq_oe_l),
    .dram_rwds_out  (dram_rwds_out),
    .dram_rwds_oe_l (dram_rwds_oe_l),
    .dram_ck        (dram_ck),
    .dram_cs_l      (dram_cs_l)
  );

  // --------------------------------------------------------------------------
  // Read return register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_rdy <= 1'b0;
    end else begin
      rd_rdy <= word_done;
    end
  end

  // Word is held until the next read completes
  always_ff @(posedge clk) begin
    if (word_done) begin
      rd_d <= word;
    end
  end

endmodule

/* verification/hyper_ram_model.sv */
// Behavioral HyperRAM with memory array, configuration register and strobed reads
module hyper_ram_model
  import hyper_pkg::*;
(
  input  logic            ck,
  input  logic            cs_l,
  input  logic [DQ_W-1:0] ctrl_dq,
  input  logic            ctrl_dq_oe_l,
  input  logic            ctrl_rwds,
  input  logic            ctrl_rwds_oe_l,
  input  logic            want_2x,
  output logic [DQ_W-1:0] mem_dq,
  output logic            mem_rwds
);

  // Six CA bytes, the seventh slot is padding
  localparam int CA_BYTES = 6;
  // Fixed read latency in DRAM clock edges
  localparam int READ_GAP = 12;
  localparam int RD_FIRST = CA_BYTES + READ_GAP;

  logic [WORD_W-1:0] mem [0:255];
  logic [15:0]       cfg_reg;
  logic [CA_W-1:0]   last_ca;
  logic [CA_W-1:0]   ca_sr;
  logic [DQ_W-1:0]   ring [0:3];
  logic [3:0]        ring_mask;
  logic [WORD_W-1:0] rd_word;
  logic              active;
  int                edge_idx;
  int                rd_pos;

  initial begin
    // Every word differs, so a wrong address shows up in the data
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h9e3779b9 * (i + 1);
    end
    cfg_reg   = 16'h8f1f;
    last_ca   = '0;
    ca_sr     = '0;
    ring_mask = 4'hf;
    rd_word   = '0;
    active    = 1'b0;
    edge_idx  = 0;
    mem_dq    = '0;
    mem_rwds  = 1'b0;
  end

  // --------------------------------------------------------------------------
  // Transaction start, RWDS high during CA asks for 2x latency
  // --------------------------------------------------------------------------
  always @(negedge cs_l) begin
    #1;
    active   = 1'b1;
    edge_idx = 0;
    mem_rwds = want_2x;
  end

  // Both clock edges, pins read just after the edge where they are settled
  always @(ck) begin
    #1;
    if (!cs_l && active) begin
      if (!ctrl_dq_oe_l) begin
        if (edge_idx < CA_BYTES) begin
          ca_sr = {ca_sr[CA_W-DQ_W-1:0], ctrl_dq};
          if (edge_idx == CA_BYTES - 1) begin
            last_ca  = ca_sr;
            rd_word  = mem[ca_sr[23:16]];
            mem_rwds = 1'b0;
          end
        end
        // Last four driven bytes with their write masks
        ring[0]   = ring[1];
        ring[1]   = ring[2];
        ring[2]   = ring[3];
        ring[3]   = ctrl_dq;
        ring_mask = {ring_mask[2:0], ctrl_rwds_oe_l | ctrl_rwds};
      end
      // Read data, one byte per edge with RWDS toggling
      if (last_ca[CA_RW_BIT] && edge_idx >= RD_FIRST && edge_idx < RD_FIRST + MEM_BYTES) begin
        rd_pos   = edge_idx - RD_FIRST;
        mem_dq   = rd_word[WORD_W-1-DQ_W*rd_pos -: DQ_W];
        mem_rwds = (rd_pos % 2 == 0);
      end
      edge_idx++;
    end
  end

  // --------------------------------------------------------------------------
  // Commit writes when CS goes back high
  // --------------------------------------------------------------------------
  always @(posedge cs_l) begin
    if (active) begin
      active = 1'b0;
      if (!last_ca[CA_RW_BIT]) begin
        if (last_ca[CA_AS_BIT]) begin
          cfg_reg = {ring[2], ring[3]};
        end else begin
          for (int i = 0; i < MEM_BYTES; i++) begin
            if (!ring_mask[3-i]) begin
              mem[last_ca[23:16]][WORD_W-1-DQ_W*i -: DQ_W] = ring[i];
            end
          end
        end
      end
      mem_dq   = '0;
      mem_rwds = 1'b0;
    end
  end

endmodule

/* verification/tb_hyper_ctrl.sv */
// Testbench for the HyperRAM controller against a behavioral HyperRAM
module tb_hyper_ctrl
  import hyper_pkg::*;
();

  localparam int         CLK_PERIOD = 20;
  // About 38 transactions in all, each well under the per-transaction budget
  localparam int         NUM_XACT   = 40;
  localparam int         XACT_CLKS  = 200;
  localparam logic [7:0] LAT_1X     = 8'h12;
  localparam logic [7:0] LAT_2X     = 8'h16;

  logic              clk;
  logic              reset;
  logic              rd_req;
  logic              wr_req;
  logic              mem_or_reg;
  logic [BE_W-1:0]   wr_byte_en;
  logic [WORD_W-1:0] addr;
  logic [WORD_W-1:0] wr_d;
  logic [7:0]        latency_1x;
  logic [7:0]        latency_2x;
  logic [WORD_W-1:0] rd_d;
  logic              rd_rdy;
  logic              busy;
  logic [DQ_W-1:0]   dram_dq_out;
  logic              dram_dq_oe_l;
  logic              dram_rwds_out;
  logic              dram_rwds_oe_l;
  logic              dram_ck;
  logic              dram_rst_l;
  logic              dram_cs_l;
  logic [DQ_W-1:0]   ram_dq;
  logic              ram_rwds;
  logic              want_2x;
  logic [31:0]       seed;
  int                clks_since_reset;
  logic [WORD_W-1:0] snap [0:255];

  hyper_ctrl_top uut (
    .clk(clk), .reset(reset), .rd_req(rd_req), .wr_req(wr_req), .mem_or_reg(mem_or_reg),
    .wr_byte_en(wr_byte_en), .addr(addr), .wr_d(wr_d),
    .latency_1x(latency_1x), .latency_2x(latency_2x),
    .rd_d(rd_d), .rd_rdy(rd_rdy), .busy(busy),
    .dram_dq_in(ram_dq), .dram_dq_out(dram_dq_out), .dram_dq_oe_l(dram_dq_oe_l),
    .dram_rwds_in(ram_rwds), .dram_rwds_out(dram_rwds_out), .dram_rwds_oe_l(dram_rwds_oe_l),
    .dram_ck(dram_ck), .dram_rst_l(dram_rst_l), .dram_cs_l(dram_cs_l)
  );

  hyper_ram_model ram (
    .ck(dram_ck), .cs_l(dram_cs_l), .ctrl_dq(dram_dq_out), .ctrl_dq_oe_l(dram_dq_oe_l),
    .ctrl_rwds(dram_rwds_out), .ctrl_rwds_oe_l(dram_rwds_oe_l), .want_2x(want_2x),
    .mem_dq(ram_dq), .mem_rwds(ram_rwds)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    clks_since_reset <= reset ? 0 : clks_since_reset + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // --------------------------------------------------------------------------
  // Checks on the pins
  // --------------------------------------------------------------------------
  assert property (@(posedge clk) dram_rst_l == !reset)
    else stop_on_error("DRAM reset pin does not follow the core reset");
  assert property (@(posedge clk) disable iff (reset) !busy |-> dram_cs_l)
    else stop_on_error("Chip select is low while the controller is idle");
  assert property (@(posedge clk) disable iff (reset)
    clks_since_reset < RESET_HOLD |-> dram_cs_l && dram_dq_oe_l && dram_rwds_oe_l && !rd_rdy)
    else stop_on_error("DRAM pins became active during the power-up hold");
  assert property (@(posedge clk) disable iff (reset) rd_rdy |-> busy)
    else stop_on_error("Read data returned after the transaction ended");

  task automatic check_value(input string test, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp)
      else stop_on_error($sformatf("Mismatch %s expected %h actual %h", test, exp, got));
  endtask

  task automatic wait_idle();
    do @(negedge clk); while (busy);
  endtask

  task automatic write_word(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] d,
                            input logic [BE_W-1:0] be, input logic reg_space);
    @(posedge clk);
    #1;
    addr       = a;
    wr_d       = d;
    wr_byte_en = be;
    mem_or_reg = reg_space;
    wr_req     = 1'b1;
    @(posedge clk);
    #1;
    wr_req     = 1'b0;
    wait_idle();
  endtask

  // Counts rd_rdy pulses until busy falls
  task automatic read_word(input logic [WORD_W-1:0] a, output logic [WORD_W-1:0] d,
                           output int pulses);
    @(posedge clk);
    #1;
    addr       = a;
    mem_or_reg = 1'b0;
    rd_req     = 1'b1;
    @(posedge clk);
    #1;
    rd_req = 1'b0;
    pulses = 0;
    d      = '0;
    do begin
      @(negedge clk);
      if (rd_rdy) begin
        pulses++;
        d = rd_d;
      end
    end while (busy);
  endtask

  // Read CA: read bit, memory space, linear burst, word address split
  function automatic logic [CA_W-1:0] read_ca_for(input logic [WORD_W-1:0] a);
    logic [CA_W-1:0] ca;
    ca        = '0;
    ca[47]    = 1'b1;
    ca[45]    = 1'b1;
    ca[44:16] = a[30:2];
    ca[2:0]   = {a[1:0], 1'b0};
    return ca;
  endfunction

  // Eight random writes, then read back each one
  // wr_time is how long the last write took, hold already over
  task automatic write_read_pass(input string test, output time wr_time);
    logic [WORD_W-1:0] addrs [0:7];
    logic [WORD_W-1:0] data [0:7];
    logic [WORD_W-1:0] got;
    logic [31:0]       r;
    int                pulses;
    time               t_start;
    for (int i = 0; i < 8; i++) begin
      r        = $random(seed);
      addrs[i] = {22'd0, r[7:4], 4'(i), 2'b00};
      data[i]  = $random(seed);
      t_start  = $time;
      write_word(addrs[i], data[i], 4'hf, 1'b0);
      wr_time  = $time - t_start;
    end
    for (int i = 0; i < 8; i++) begin
      read_word(addrs[i], got, pulses);
      check_value({test, "_data"}, 64'(data[i]), 64'(got));
      check_value({test, "_rdy_pulses"}, 64'd1, 64'(pulses));
      check_value({test, "_ca"}, 64'(read_ca_for(addrs[i])), 64'(ram.last_ca));
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    logic [WORD_W-1:0] got;
    logic [WORD_W-1:0] old;
    int                pulses;
    time               wr_time_1x;
    time               wr_time_2x;
    clk        = 1'b0;
    reset      = 1'b1;
    rd_req     = 1'b0;
    wr_req     = 1'b0;
    mem_or_reg = 1'b0;
    wr_byte_en = '0;
    addr       = '0;
    wr_d       = '0;
    latency_1x = LAT_1X;
    latency_2x = LAT_2X;
    want_2x    = 1'b0;
    seed       = 32'h2f4b75ff;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("reset_state", 64'b111000,
                64'({dram_cs_l, dram_dq_oe_l, dram_rwds_oe_l, busy, rd_rdy, dram_ck}));

    // First request lands inside the power-up hold
    write_read_pass("write_read_1x", wr_time_1x);
    want_2x = 1'b1;
    write_read_pass("write_read_2x", wr_time_2x);
    want_2x = 1'b0;
    // Only the write wait differs, by the gap between the two latency settings
    check_value("write_latency_2x", 64'((LAT_2X - LAT_1X) * CLK_PERIOD),
                64'(wr_time_2x - wr_time_1x));

    // Partial write keeps bytes 2 and 0
    write_word(32'h0000_0030, 32'h1122_3344, 4'hf, 1'b0);
    write_word(32'h0000_0030, 32'hAABB_CCDD, 4'b1010, 1'b0);
    read_word(32'h0000_0030, got, pulses);
    check_value("partial_write", 64'h0000_0000_AA22_CC44, 64'(got));

    // Register write leaves the array alone
    for (int i = 0; i < 256; i++) begin
      snap[i] = ram.mem[i];
    end
    write_word(32'h0000_0800, 32'h8fe4_0000, 4'hf, 1'b1);
    check_value("reg_write_cfg", 64'h8fe4, 64'(ram.cfg_reg));
    check_value("reg_write_space", 64'd1, 64'(ram.last_ca[CA_AS_BIT]));
    check_value("reg_write_addr", 64'h100, 64'(ram.last_ca[44:16]));
    for (int i = 0; i < 256; i++) begin
      check_value("reg_write_mem", 64'(snap[i]), 64'(ram.mem[i]));
    end

    // Second request while busy must be dropped
    old = ram.mem[8'h0d];
    @(posedge clk);
    #1;
    addr       = 32'h0000_0038;
    wr_d       = 32'h5a5a_0f0f;
    wr_byte_en = 4'hf;
    mem_or_reg = 1'b0;
    wr_req     = 1'b1;
    @(posedge clk);
    #1;
    wr_req = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    check_value("ignored_req_busy", 64'd1, 64'(busy));
    addr   = 32'h0000_0034;
    wr_d   = 32'hdead_beef;
    wr_req = 1'b1;
    @(posedge clk);
    #1;
    wr_req = 1'b0;
    wait_idle();
    check_value("ignored_req_mem", 64'(old), 64'(ram.mem[8'h0d]));
    check_value("ignored_req_first", 64'h5a5a_0f0f, 64'(ram.mem[8'h0e]));

    $display("TEST PASS");
    $finish;
  end

  // Watchdog sized from the transaction count
  initial begin
    #(CLK_PERIOD * NUM_XACT * XACT_CLKS);
    stop_on_error("Watchdog expired before the tests completed");
  end

endmodule

/* flist.f */
rtl/hyper_pkg.sv
rtl/hyper_pins_if.sv
rtl/hyper_sequencer.sv
rtl/hyper_read_capture.sv
rtl/hyper_pad_stage.sv
rtl/hyper_ctrl_top.sv
verification/hyper_ram_model.sv
verification/tb_hyper_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the HyperRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_hyper_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
